// ==== hw/burst_seq.sv ====
`timescale 1ns/1ps
`include "lane_ram_settings.svh"

module burst_seq (
    input  logic                         clk,
    input  logic                         i_arst_n,
    input  logic                         i_enable,
    input  logic [`LANE_RAM_ADDR_W-1:0]  i_addr,
    input  logic [3:0]                   i_be,
    output logic [`LANE_RAM_ADDR_W-1:0]  o_eff_addr,
    output lane_ram_pkg::acc_size_e      o_size,
    output logic                         o_wr_permit,
    output logic                         o_ready,
    output logic                         o_bus_err
);

    logic [`LANE_RAM_OFFSET_W-1:0] offset_q;
    logic [`LANE_RAM_OFFSET_W-1:0] step;
    logic                          first_q;
    logic                          err_q;
    logic                          misaligned;
    logic                          access_ok;

    // Byte enable to access size, with the matching offset step
    always_comb begin
        case (i_be)
            4'b1111: begin
                o_size = lane_ram_pkg::SIZE_WORD;
                step   = `LANE_RAM_OFFSET_W'(4);
            end
            4'b0011: begin
                o_size = lane_ram_pkg::SIZE_HALF;
                step   = `LANE_RAM_OFFSET_W'(2);
            end
            4'b0001: begin
                o_size = lane_ram_pkg::SIZE_BYTE;
                step   = `LANE_RAM_OFFSET_W'(1);
            end
            default: begin
                o_size = lane_ram_pkg::SIZE_BAD;
                step   = '0;
            end
        endcase
    end

    // Base address plus the running burst offset
    assign o_eff_addr = i_addr +
        {{(`LANE_RAM_ADDR_W - `LANE_RAM_OFFSET_W){1'b0}}, offset_q};

    always_comb begin
        case (o_size)
            lane_ram_pkg::SIZE_WORD: misaligned = (o_eff_addr[1:0] != 2'b00);
            lane_ram_pkg::SIZE_HALF: misaligned = o_eff_addr[0];
            default:                 misaligned = 1'b0;
        endcase
    end

    assign access_ok = !misaligned && (o_size != lane_ram_pkg::SIZE_BAD);

    // Writes stop for the bad access and for every access after it
    assign o_wr_permit = i_enable && access_ok && !err_q;

    assign o_ready   = i_enable && !first_q;
    assign o_bus_err = err_q;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            offset_q <= '0;
            first_q  <= 1'b1;
            err_q    <= 1'b0;
        end else if (!i_enable) begin
            // Burst closed, start over on the next enable
            offset_q <= '0;
            first_q  <= 1'b1;
            err_q    <= 1'b0;
        end else begin
            first_q <= 1'b0;
            // Offset holds once an error is latched
            if (!err_q) begin
                if (access_ok) begin
                    offset_q <= offset_q + step;
                end else begin
                    err_q <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== hw/byte_lane_ram.sv ====
`timescale 1ns/1ps
`include "lane_ram_settings.svh"

module byte_lane_ram (
    input  logic                    clk,
    input  logic                    i_we,
    input  lane_ram_pkg::lane_addr_t i_addr,
    input  logic [7:0]              i_wdata,
    output logic [7:0]              o_rdata
);

    // One byte of every memory word
    logic [7:0] mem [`LANE_RAM_DEPTH];

    // Single port, read-first
    // A write in the same cycle leaves the old byte on the output
    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_addr] <= i_wdata;
        end
        o_rdata <= mem[i_addr];
    end

endmodule

// ==== hw/lane_ram_pkg.sv ====
`include "lane_ram_settings.svh"

package lane_ram_pkg;

    // Bits needed to index one word of a lane
    localparam int LANE_ADDR_W = $clog2(`LANE_RAM_DEPTH);

    // Access size as decoded from the 4-bit byte enable
    typedef enum logic [1:0] {
        SIZE_WORD = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_BYTE = 2'd2,
        SIZE_BAD  = 2'd3
    } acc_size_e;

    // One bus request as presented by the processor
    typedef struct packed {
        logic [`LANE_RAM_ADDR_W-1:0] addr;
        logic [31:0]                 wdata;
        logic [3:0]                  be;
        logic                        wr_en;
    } mem_req_t;

    // One memory word, seen whole, as halfwords or as bytes
    // half[1] and bytes[3] are the most significant parts
    typedef union packed {
        logic [31:0]      word;
        logic [1:0][15:0] half;
        logic [3:0][7:0]  bytes;
    } mem_word_u;

    // Word index into a single lane
    typedef logic [LANE_ADDR_W-1:0] lane_addr_t;

endpackage

// ==== hw/lane_ram_top.sv ====
`timescale 1ns/1ps
`include "lane_ram_settings.svh"

module lane_ram_top (
    input  logic                   clk,
    input  logic                   i_arst_n,
    input  logic                   i_enable,
    input  lane_ram_pkg::mem_req_t i_req,
    output logic [31:0]            o_rdata,
    output logic                   o_ready,
    output logic                   o_bus_err
);

    logic [`LANE_RAM_ADDR_W-1:0] eff_addr;
    lane_ram_pkg::acc_size_e     size;
    lane_ram_pkg::lane_addr_t    lane_addr;
    logic                        wr_permit;
    logic [3:0]                  lane_we;
    logic [31:0]                 lane_wdata;
    logic [31:0]                 lane_rdata;

    // Word index shared by all four lanes
    assign lane_addr = eff_addr[2 +: lane_ram_pkg::LANE_ADDR_W];

    burst_seq u_burst_seq (
        .clk         (clk),
        .i_arst_n    (i_arst_n),
        .i_enable    (i_enable),
        .i_addr      (i_req.addr),
        .i_be        (i_req.be),
        .o_eff_addr  (eff_addr),
        .o_size      (size),
        .o_wr_permit (wr_permit),
        .o_ready     (o_ready),
        .o_bus_err   (o_bus_err)
    );

    lane_steer u_lane_steer (
        .clk          (clk),
        .i_arst_n     (i_arst_n),
        .i_enable     (i_enable),
        .i_wr_en      (i_req.wr_en),
        .i_wr_permit  (wr_permit),
        .i_size       (size),
        .i_byte_off   (eff_addr[1:0]),
        .i_wdata      (i_req.wdata),
        .i_lane_rdata (lane_rdata),
        .o_lane_we    (lane_we),
        .o_lane_wdata (lane_wdata),
        .o_rdata      (o_rdata)
    );

    // Lane k holds byte k of every word
    for (genvar k = 0; k < 4; k++) begin : g_lane
        byte_lane_ram u_lane (
            .clk     (clk),
            .i_we    (lane_we[k]),
            .i_addr  (lane_addr),
            .i_wdata (lane_wdata[8*k +: 8]),
            .o_rdata (lane_rdata[8*k +: 8])
        );
    end

endmodule

// ==== hw/lane_steer.sv ====
`timescale 1ns/1ps

module lane_steer (
    input  logic                    clk,
    input  logic                    i_arst_n,
    input  logic                    i_enable,
    input  logic                    i_wr_en,
    input  logic                    i_wr_permit,
    input  lane_ram_pkg::acc_size_e i_size,
    input  logic [1:0]              i_byte_off,
    input  logic [31:0]             i_wdata,
    input  logic [31:0]             i_lane_rdata,
    output logic [3:0]              o_lane_we,
    output logic [31:0]             o_lane_wdata,
    output logic [31:0]             o_rdata
);

    lane_ram_pkg::mem_word_u wdata_in;
    lane_ram_pkg::mem_word_u wdata_steer;
    lane_ram_pkg::mem_word_u rdata_lane;
    lane_ram_pkg::mem_word_u rdata_ext;
    lane_ram_pkg::acc_size_e size_q;
    logic [1:0]              byte_off_q;
    logic                    rd_valid_q;
    logic [3:0]              we_mask;

    // Write side: move the low part of the bus word onto its lanes
    always_comb begin
        wdata_in.word    = i_wdata;
        wdata_steer.word = '0;
        we_mask          = 4'b0000;
        case (i_size)
            lane_ram_pkg::SIZE_WORD: begin
                wdata_steer.word = wdata_in.word;
                we_mask          = 4'b1111;
            end
            lane_ram_pkg::SIZE_HALF: begin
                wdata_steer.half[i_byte_off[1]] = wdata_in.half[0];
                we_mask = i_byte_off[1] ? 4'b1100 : 4'b0011;
            end
            lane_ram_pkg::SIZE_BYTE: begin
                wdata_steer.bytes[i_byte_off] = wdata_in.bytes[0];
                we_mask = 4'b0001 << i_byte_off;
            end
            default: begin
                // Bad size writes nothing
                we_mask = 4'b0000;
            end
        endcase
    end

    assign o_lane_wdata = wdata_steer.word;
    assign o_lane_we    = (i_wr_en && i_wr_permit) ? we_mask : 4'b0000;

    // Size and lane offset follow the RAM data by one cycle
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            size_q     <= lane_ram_pkg::SIZE_WORD;
            byte_off_q <= 2'b00;
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= i_enable;
            if (i_enable) begin
                size_q     <= i_size;
                byte_off_q <= i_byte_off;
            end
        end
    end

    // Read side: pull the addressed part down to bit 0, zero-extended
    always_comb begin
        rdata_lane.word = i_lane_rdata;
        rdata_ext.word  = '0;
        case (size_q)
            lane_ram_pkg::SIZE_WORD: rdata_ext.word     = rdata_lane.word;
            lane_ram_pkg::SIZE_HALF: rdata_ext.half[0]  = rdata_lane.half[byte_off_q[1]];
            lane_ram_pkg::SIZE_BYTE: rdata_ext.bytes[0] = rdata_lane.bytes[byte_off_q];
            default:                 rdata_ext.word     = '0;
        endcase
    end

    // No data before the first access of a burst has returned
    assign o_rdata = (i_enable && rd_valid_q) ? rdata_ext.word : '0;

endmodule

// ==== include/lane_ram_settings.svh ====
`ifndef LANE_RAM_SETTINGS_SVH
`define LANE_RAM_SETTINGS_SVH

// Width of the processor data bus address
`define LANE_RAM_ADDR_W 32

// Words held by each byte lane
// The lane index comes from effective address bits [2 +: log2(depth)]
`define LANE_RAM_DEPTH 256

// Burst offset register width
// A burst wraps its offset every 256 bytes
`define LANE_RAM_OFFSET_W 8

`endif

// ==== lane_ram.f ====
+incdir+include
hw/lane_ram_pkg.sv
hw/byte_lane_ram.sv
hw/burst_seq.sv
hw/lane_steer.sv
hw/lane_ram_top.sv
testbench/tb_lane_ram.sv

// ==== testbench/tb_lane_ram.sv ====
`timescale 1ns/1ps
`include "lane_ram_settings.svh"

module tb_lane_ram;

    localparam int MEM_BYTES   = 4 * `LANE_RAM_DEPTH;
    localparam int BURST_BYTES = 1 << `LANE_RAM_OFFSET_W;
    localparam int MAX_CYCLES  = 600;

    logic                   clk;
    logic                   i_arst_n;
    logic                   i_enable;
    lane_ram_pkg::mem_req_t i_req;
    logic [31:0]            o_rdata;
    logic                   o_ready;
    logic                   o_bus_err;

    // Reference model of the memory and the burst state
    logic [7:0]                    model_mem [MEM_BYTES];
    bit                            model_known [MEM_BYTES];
    logic [`LANE_RAM_OFFSET_W-1:0] model_offset;
    logic                          model_first;
    logic                          model_err;
    logic                          model_rd_valid;
    logic [31:0]                   next_rdata;
    logic                          next_known;

    // Expected outputs up to the next rising edge
    logic [31:0] exp_rdata;
    logic        exp_rdata_chk;
    logic        exp_ready;
    logic        exp_err;

    int seed      = 25;
    int cycle_cnt = 0;

    lane_ram_top dut_i (
        .clk       (clk),
        .i_arst_n  (i_arst_n),
        .i_enable  (i_enable),
        .i_req     (i_req),
        .o_rdata   (o_rdata),
        .o_ready   (o_ready),
        .o_bus_err (o_bus_err)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] got);
        abort_run($sformatf("error %s expected 0x%h got 0x%h", name, exp, got));
    endtask

    rdata_match: assert property (@(posedge clk) disable iff (!i_arst_n)
        !exp_rdata_chk || (o_rdata == exp_rdata))
        else report_mismatch("o_rdata", $sampled(exp_rdata), $sampled(o_rdata));

    ready_match: assert property (@(posedge clk) disable iff (!i_arst_n)
        o_ready == exp_ready)
        else report_mismatch("o_ready", 32'($sampled(exp_ready)), 32'($sampled(o_ready)));

    err_match: assert property (@(posedge clk) disable iff (!i_arst_n)
        o_bus_err == exp_err)
        else report_mismatch("o_bus_err", 32'($sampled(exp_err)), 32'($sampled(o_bus_err)));

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            abort_run($sformatf("timeout, the run did not finish in %0d cycles", MAX_CYCLES));
        end
    end

    // Bytes moved by one access or zero for an illegal byte enable
    function automatic int access_bytes(input logic [3:0] be);
        case (be)
            4'b1111: return 4;
            4'b0011: return 2;
            4'b0001: return 1;
            default: return 0;
        endcase
    endfunction

    function automatic int byte_index(input logic [31:0] addr);
        return int'(addr % 32'(MEM_BYTES));
    endfunction

    // Preload pattern built from all ten byte-address bits
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return {6'h2d, addr[9:0], 6'h12, ~addr[9:0]};
    endfunction

    // One clock of stimulus with the model stepped to the next edge
    task automatic drive_cycle(input logic en, input logic [31:0] base,
                               input logic [31:0] wdata, input logic [3:0] be,
                               input logic wr);
        logic [31:0] addr;
        logic [31:0] rd;
        logic        ok;
        logic        known;
        int          nbytes;
        int          idx;
        @(negedge clk);
        i_enable    = en;
        i_req.addr  = base;
        i_req.wdata = wdata;
        i_req.be    = be;
        i_req.wr_en = wr;
        exp_ready   = en && !model_first;
        exp_err     = model_err;
        exp_rdata     = (en && model_rd_valid) ? next_rdata : '0;
        exp_rdata_chk = (en && model_rd_valid) ? next_known : 1'b1;
        if (!en) begin
            model_offset   = '0;
            model_first    = 1'b1;
            model_err      = 1'b0;
            model_rd_valid = 1'b0;
        end else begin
            addr   = base + 32'(model_offset);
            nbytes = access_bytes(be);
            ok     = (nbytes == 1) || (nbytes == 2 && !addr[0]) ||
                     (nbytes == 4 && addr[1:0] == 2'b00);
            rd     = '0;
            known  = ok;
            for (int i = 0; i < nbytes; i++) begin
                idx          = byte_index(addr + 32'(i));
                rd[8*i +: 8] = model_mem[idx];
                known        = known && model_known[idx];
            end
            // The read above sees the bytes from before this write
            if (wr && ok && !model_err) begin
                for (int i = 0; i < nbytes; i++) begin
                    idx              = byte_index(addr + 32'(i));
                    model_mem[idx]   = wdata[8*i +: 8];
                    model_known[idx] = 1'b1;
                end
            end
            if (!model_err) begin
                if (ok) begin
                    model_offset = model_offset + `LANE_RAM_OFFSET_W'(nbytes);
                end else begin
                    model_err = 1'b1;
                end
            end
            model_first    = 1'b0;
            model_rd_valid = 1'b1;
            next_rdata     = rd;
            next_known     = known;
        end
    endtask

    task automatic release_enable(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            drive_cycle(1'b0, '0, '0, 4'b0000, 1'b0);
        end
    endtask

    task automatic write_burst(input logic [31:0] base, input logic [3:0] be, input int beats);
        for (int i = 0; i < beats; i++) begin
            drive_cycle(1'b1, base, $random(seed), be, 1'b1);
        end
    endtask

    // One extra beat so the last access shows up on o_rdata
    task automatic read_burst(input logic [31:0] base, input logic [3:0] be, input int beats);
        for (int i = 0; i <= beats; i++) begin
            drive_cycle(1'b1, base, $random(seed), be, 1'b0);
        end
    endtask

    initial begin
        logic [31:0] base;
        i_arst_n       = 1'b0;
        i_enable       = 1'b0;
        i_req          = '0;
        model_offset   = '0;
        model_first    = 1'b1;
        model_err      = 1'b0;
        model_rd_valid = 1'b0;
        next_rdata     = '0;
        next_known     = 1'b0;
        exp_rdata      = '0;
        exp_rdata_chk  = 1'b1;
        exp_ready      = 1'b0;
        exp_err        = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        i_arst_n = 1'b1;

        // Preload every byte with a known pattern
        for (int blk = 0; blk < MEM_BYTES / BURST_BYTES; blk++) begin
            for (int w = 0; w < BURST_BYTES / 4; w++) begin
                drive_cycle(1'b1, 32'(blk * BURST_BYTES),
                            fill_word(32'(blk * BURST_BYTES + 4 * w)), 4'b1111, 1'b1);
            end
            release_enable(1);
        end

        // Word, halfword and byte bursts written and read back
        base = $random(seed) & ~32'h3;
        write_burst(base, 4'b1111, 8);
        release_enable(1);
        read_burst(base, 4'b1111, 8);
        release_enable(1);
        base = $random(seed) & ~32'h1;
        write_burst(base, 4'b0011, 8);
        release_enable(1);
        read_burst(base, 4'b0011, 8);
        release_enable(1);
        base = $random(seed);
        write_burst(base, 4'b0001, 8);
        release_enable(1);
        read_burst(base, 4'b0001, 8);
        release_enable(1);

        // Misaligned word and halfword leave memory untouched
        base = $random(seed) & ~32'h3;
        write_burst(base | 32'h1, 4'b1111, 4);
        release_enable(1);
        read_burst(base, 4'b1111, 4);
        release_enable(1);
        base = $random(seed) | 32'h1;
        write_burst(base, 4'b0011, 4);
        release_enable(1);
        read_burst(base & ~32'h1, 4'b0011, 2);
        release_enable(1);

        // Illegal byte enable in the middle of a write burst
        base = $random(seed) & ~32'h3;
        write_burst(base, 4'b1111, 2);
        drive_cycle(1'b1, base, $random(seed), 4'b0110, 1'b1);
        write_burst(base, 4'b1111, 3);
        release_enable(1);
        read_burst(base, 4'b1111, 4);
        release_enable(1);

        // Enable low clears the error and restarts the offset
        write_burst(($random(seed) & ~32'h3) | 32'h2, 4'b1111, 2);
        release_enable(2);
        base = $random(seed) & ~32'h3;
        write_burst(base, 4'b1111, 3);
        release_enable(1);
        read_burst(base, 4'b1111, 3);
        release_enable(1);

        // Writes and reads alternating within one burst
        base = $random(seed) & ~32'h3;
        for (int i = 0; i < 10; i++) begin
            drive_cycle(1'b1, base, $random(seed), 4'b1111, (i % 2) == 0);
        end
        release_enable(1);
        read_burst(base, 4'b1111, 10);
        release_enable(1);
        base = $random(seed);
        for (int i = 0; i < 12; i++) begin
            drive_cycle(1'b1, base, $random(seed), 4'b0001, (i % 2) == 1);
        end
        release_enable(1);
        read_burst(base, 4'b0001, 12);
        release_enable(2);
        @(negedge clk);

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule
